// ==== flist.f ====
hw/book_pkg.sv
hw/book_cmd_port.sv
hw/book_match.sv
hw/book_update.sv
hw/book_state.sv
hw/book_top.sv
sim/tb_book.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the order book simulation with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_book \
  -f flist.f

./obj_dir/Vtb_book | tee sim.log

if grep -q "^sim passed$" sim.log; then
  echo "Simulation result: PASS"
else
  echo "Simulation result: FAIL"
  exit 1
fi

// ==== sim/tb_book.sv ====
// Order book testbench
module tb_book import book_pkg::*; ();

  // Cycles allowed from request to ack before a row gives up
  localparam int ACK_WAIT_MAX = 8;

  logic    i_clk;
  logic    i_arst_n;
  logic    i_req;
  cmd_t    i_cmd;
  key_t    i_key;
  volume_t i_volume;
  logic    o_ack;
  logic    o_notify_vld;
  key_t    o_notify_key;
  volume_t o_notify_volume;
  count_t  o_count;
  key_t    o_best_key;
  volume_t o_best_volume;

  // Command table, stimulus columns then expected columns
  cmd_t    tbl_cmd[$];
  key_t    tbl_key[$];
  volume_t tbl_volume[$];
  count_t  tbl_count[$];
  key_t    tbl_best_key[$];
  volume_t tbl_best_volume[$];
  logic    tbl_notify[$];
  key_t    tbl_notify_key[$];
  volume_t tbl_notify_volume[$];

  // Reference book, index 0 is the best price
  key_t    ref_keys[ENTRIES_N];
  volume_t ref_volumes[ENTRIES_N];
  int      ref_count;
  key_t    lost_key;
  key_t    used_keys[$];

  logic [31:0] lfsr_state;
  int          row_errors;
  int          pass_count;
  int          fail_count;
  int          cycle_count = 0;
  int          cycle_limit = 0;

  book_top DUT (
      .i_clk(i_clk), .i_arst_n(i_arst_n), .i_req(i_req)
    , .i_cmd(i_cmd), .i_key(i_key), .i_volume(i_volume)
    , .o_ack(o_ack), .o_notify_vld(o_notify_vld), .o_notify_key(o_notify_key)
    , .o_notify_volume(o_notify_volume), .o_count(o_count)
    , .o_best_key(o_best_key), .o_best_volume(o_best_volume)
  );

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  // Watchdog on total run length
  always @(posedge i_clk) begin
    cycle_count <= cycle_count + 1;
    if ((cycle_limit > 0) && (cycle_count >= cycle_limit)) begin
      $display("Timeout: run went past %0d cycles without finishing", cycle_limit);
      $display("sim failed");
      $finish;
    end
  end

  // Galois LFSR, right shift, taps 32 30 26 25
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'hA3000000;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int b = 0; b < n; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // Unused key, clear of the fixed extremes used below
  function automatic key_t fresh_key();
    key_t k;
    logic dup;
    do begin
      k   = key_t'(take_bits(KEY_BITS));
      dup = (k < 16'h0100) || (k > 16'hfeff);
      foreach (used_keys[j]) begin
        if (used_keys[j] == k) dup = 1'b1;
      end
    end while (dup);
    used_keys.push_back(k);
    return k;
  endfunction

  // Apply one command to the reference book and record the row
  task automatic append_row(input cmd_t cmd, input key_t key, input volume_t volume);
    int      pos;
    int      hit;
    logic    notify;
    key_t    prev_key;
    volume_t prev_volume;
    // Empty entries hold zero, so this is zero for an empty book
    prev_key    = ref_keys[0];
    prev_volume = ref_volumes[0];
    notify      = 1'b0;
    hit         = -1;
    for (int j = 0; j < ref_count; j++) begin
      if (ref_keys[j] == key) hit = j;
    end
    case (cmd)
      CMD_CLEAR: begin
        notify = (ref_count > 0);
        for (int j = 0; j < ENTRIES_N; j++) begin
          ref_keys[j]    = '0;
          ref_volumes[j] = '0;
        end
        ref_count = 0;
      end
      CMD_ADD: begin
        // Higher keys keep their place
        pos = 0;
        while ((pos < ref_count) && (ref_keys[pos] >= key)) pos++;
        notify = (pos == 0);
        if (pos < ENTRIES_N) begin
          if (ref_count == ENTRIES_N) lost_key = ref_keys[ENTRIES_N-1];
          for (int j = ENTRIES_N - 1; j > pos; j--) begin
            ref_keys[j]    = ref_keys[j-1];
            ref_volumes[j] = ref_volumes[j-1];
          end
          ref_keys[pos]    = key;
          ref_volumes[pos] = volume;
        end else begin
          // Below a full book, the new key itself drops out
          lost_key = key;
        end
        if (ref_count < ENTRIES_N) ref_count++;
      end
      CMD_DELETE: begin
        if (hit >= 0) begin
          notify = (hit == 0);
          for (int j = hit; j < ENTRIES_N - 1; j++) begin
            ref_keys[j]    = ref_keys[j+1];
            ref_volumes[j] = ref_volumes[j+1];
          end
          ref_keys[ENTRIES_N-1]    = '0;
          ref_volumes[ENTRIES_N-1] = '0;
          ref_count--;
        end
      end
      default: begin
        if (hit >= 0) begin
          notify           = (hit == 0);
          ref_volumes[hit] = volume;
        end
      end
    endcase
    tbl_cmd.push_back(cmd);
    tbl_key.push_back(key);
    tbl_volume.push_back(volume);
    tbl_count.push_back(count_t'(ref_count));
    tbl_best_key.push_back(ref_keys[0]);
    tbl_best_volume.push_back(ref_volumes[0]);
    tbl_notify.push_back(notify);
    tbl_notify_key.push_back(prev_key);
    tbl_notify_volume.push_back(prev_volume);
  endtask

  task automatic build_table();
    key_t    k;
    volume_t v;
    // Clear of an empty book touches nothing
    append_row(CMD_CLEAR, '0, '0);
    // Random fill, one more than fits
    for (int n = 0; n <= ENTRIES_N; n++) begin
      k = fresh_key();
      v = volume_t'(take_bits(VOLUME_BITS));
      append_row(CMD_ADD, k, v);
    end
    // Key pushed out of the full book is gone
    append_row(CMD_DELETE, lost_key, '0);
    append_row(CMD_DELETE, ref_keys[0], '0);
    k = fresh_key();
    append_row(CMD_DELETE, k, '0);
    append_row(CMD_DELETE, ref_keys[2], '0);
    v = volume_t'(take_bits(VOLUME_BITS));
    append_row(CMD_REPLACE, ref_keys[0], v);
    v = volume_t'(take_bits(VOLUME_BITS));
    append_row(CMD_REPLACE, ref_keys[3], v);
    k = fresh_key();
    v = volume_t'(take_bits(VOLUME_BITS));
    append_row(CMD_REPLACE, k, v);
    // New best, then new lowest, then a second overflow
    append_row(CMD_ADD, 16'hffff, 16'h1234);
    append_row(CMD_ADD, 16'h0001, 16'h0011);
    append_row(CMD_ADD, 16'h0002, 16'h0022);
    append_row(CMD_DELETE, 16'h0001, '0);
    append_row(CMD_CLEAR, '0, '0);
    append_row(CMD_CLEAR, '0, '0);
    // Single entry in and out again
    k = fresh_key();
    append_row(CMD_ADD, k, 16'h0bad);
    append_row(CMD_DELETE, k, '0);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      row_errors++;
    end
  endtask

  // One four-phase transfer with timing and value checks
  task automatic run_row(input int idx);
    int      n;
    int      ack_at;
    int      notify_at;
    int      notify_pulses;
    key_t    seen_key;
    volume_t seen_volume;
    cmd_t    cmd;
    n             = 0;
    ack_at        = -1;
    notify_at     = -1;
    notify_pulses = 0;
    seen_key      = '0;
    seen_volume   = '0;
    cmd           = tbl_cmd[idx];
    row_errors    = 0;
    @(posedge i_clk);
    i_req    <= 1'b1;
    i_cmd    <= cmd;
    i_key    <= tbl_key[idx];
    i_volume <= tbl_volume[idx];
    // Sample mid-cycle, n counts edges since the drive
    while ((ack_at < 0) && (n <= ACK_WAIT_MAX)) begin
      @(negedge i_clk);
      if (o_notify_vld) begin
        notify_pulses++;
        notify_at   = n;
        seen_key    = o_notify_key;
        seen_volume = o_notify_volume;
      end
      if (o_ack) ack_at = n;
      n++;
    end
    if (ack_at < 0) begin
      $display("Row %0d: no ack within %0d cycles of the request", idx, ACK_WAIT_MAX);
      row_errors++;
    end else begin
      // Req is first seen at edge 1, so ack belongs after edge 3
      if (ack_at != 3) begin
        $display("Row %0d: ack rose %0d cycles after req was seen, expected 2",
                 idx, ack_at - 1);
        row_errors++;
      end
      check_value("o_count", 32'(o_count), 32'(tbl_count[idx]));
      check_value("o_best_key", 32'(o_best_key), 32'(tbl_best_key[idx]));
      check_value("o_best_volume", 32'(o_best_volume), 32'(tbl_best_volume[idx]));
      if (tbl_notify[idx]) begin
        if ((notify_pulses != 1) || (notify_at != ack_at - 1)) begin
          $display("Row %0d: expected one notify pulse right before ack, saw %0d",
                   idx, notify_pulses);
          row_errors++;
        end
        check_value("o_notify_key", 32'(seen_key), 32'(tbl_notify_key[idx]));
        check_value("o_notify_volume", 32'(seen_volume), 32'(tbl_notify_volume[idx]));
      end else if (notify_pulses != 0) begin
        $display("Row %0d: notify raised although the best entry was untouched", idx);
        row_errors++;
      end
      @(posedge i_clk);
      i_req <= 1'b0;
      @(negedge i_clk);
      if (!o_ack || o_notify_vld) begin
        $display("Row %0d: ack dropped or notify rose before req was seen low", idx);
        row_errors++;
      end
      @(negedge i_clk);
      if (o_ack || o_notify_vld) begin
        $display("Row %0d: ack still high one edge after req was seen low", idx);
        row_errors++;
      end
    end
    if (row_errors == 0) begin
      pass_count++;
    end else begin
      fail_count++;
    end
    $display("Row %0d %s key %h volume %h: %s", idx, cmd.name(), tbl_key[idx],
             tbl_volume[idx], (row_errors == 0) ? "ok" : "FAILED");
  endtask

  initial begin
    i_arst_n    = 1'b0;
    i_req       = 1'b0;
    i_cmd       = CMD_CLEAR;
    i_key       = '0;
    i_volume    = '0;
    lfsr_state  = 32'h0e3377e6;
    ref_count   = 0;
    lost_key    = '0;
    pass_count  = 0;
    fail_count  = 0;
    for (int j = 0; j < ENTRIES_N; j++) begin
      ref_keys[j]    = '0;
      ref_volumes[j] = '0;
    end
    build_table();
    cycle_limit = 8 * tbl_cmd.size() + 100;
    repeat (16) @(posedge i_clk);
    i_arst_n <= 1'b1;
    for (int r = 0; r < tbl_cmd.size(); r++) begin
      run_row(r);
    end
    $display("Rows passed %0d, rows failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== hw/book_top.sv ====
// Bid-side order book update stage
module book_top import book_pkg::*; (
    input  logic     i_clk
  , input  logic     i_arst_n
  , input  logic     i_req
  , input  cmd_t     i_cmd
  , input  key_t     i_key
  , input  volume_t  i_volume
  , output logic     o_ack
  , output logic     o_notify_vld
  , output key_t     o_notify_key
  , output volume_t  o_notify_volume
  , output count_t   o_count
  , output key_t     o_best_key
  , output volume_t  o_best_volume
);

  // Captured command
  logic                    exec;
  cmd_t                    cmd;
  key_t                    key;
  volume_t                 volume;
  // Match results
  entry_mask_t             match_sel;
  logic                    match_hit;
  entry_mask_t             insert_sel;
  // Current and next book
  entry_mask_t             vld;
  key_t [ENTRIES_N-1:0]    keys;
  volume_t [ENTRIES_N-1:0] volumes;
  entry_mask_t             vld_nxt;
  key_t [ENTRIES_N-1:0]    keys_nxt;
  volume_t [ENTRIES_N-1:0] volumes_nxt;

  book_cmd_port u_cmd_port (
      .i_clk(i_clk), .i_arst_n(i_arst_n), .i_req(i_req)
    , .i_cmd(i_cmd), .i_key(i_key), .i_volume(i_volume)
    , .o_ack(o_ack), .o_exec(exec), .o_cmd(cmd), .o_key(key), .o_volume(volume)
  );

  book_match u_match (
      .i_key(key), .i_vld(vld), .i_keys(keys)
    , .o_match_sel(match_sel), .o_match_hit(match_hit), .o_insert_sel(insert_sel)
  );

  book_update u_update (
      .i_cmd(cmd), .i_key(key), .i_volume(volume)
    , .i_match_sel(match_sel), .i_match_hit(match_hit), .i_insert_sel(insert_sel)
    , .i_vld(vld), .i_keys(keys), .i_volumes(volumes)
    , .o_vld_nxt(vld_nxt), .o_keys_nxt(keys_nxt), .o_volumes_nxt(volumes_nxt)
  );

  // Top bits of the one-hots mark a change to the best entry
  book_state u_state (
      .i_clk(i_clk), .i_arst_n(i_arst_n), .i_exec(exec), .i_cmd(cmd)
    , .i_match_hit(match_hit)
    , .i_match_top(match_sel[ENTRIES_N-1]), .i_insert_top(insert_sel[ENTRIES_N-1])
    , .i_vld_nxt(vld_nxt), .i_keys_nxt(keys_nxt), .i_volumes_nxt(volumes_nxt)
    , .o_vld(vld), .o_keys(keys), .o_volumes(volumes), .o_count(o_count)
    , .o_notify_vld(o_notify_vld), .o_notify_key(o_notify_key)
    , .o_notify_volume(o_notify_volume)
    , .o_best_key(o_best_key), .o_best_volume(o_best_volume)
  );

endmodule

// ==== hw/book_state.sv ====
// Book registers, count and notify
module book_state import book_pkg::*; (
    input  logic                      i_clk
  , input  logic                      i_arst_n
  , input  logic                      i_exec
  , input  cmd_t                      i_cmd
  , input  logic                      i_match_hit
  , input  logic                      i_match_top
  , input  logic                      i_insert_top
  , input  entry_mask_t               i_vld_nxt
  , input  key_t [ENTRIES_N-1:0]      i_keys_nxt
  , input  volume_t [ENTRIES_N-1:0]   i_volumes_nxt
  , output entry_mask_t               o_vld
  , output key_t [ENTRIES_N-1:0]      o_keys
  , output volume_t [ENTRIES_N-1:0]   o_volumes
  , output count_t                    o_count
  , output logic                      o_notify_vld
  , output key_t                      o_notify_key
  , output volume_t                   o_notify_volume
  , output key_t                      o_best_key
  , output volume_t                   o_best_volume
);

  entry_mask_t             vld_q;
  key_t [ENTRIES_N-1:0]    keys_q;
  volume_t [ENTRIES_N-1:0] volumes_q;
  count_t                  count_q;
  count_t                  count_nxt;
  logic                    notify_q;
  logic                    notify_nxt;
  key_t                    notify_key_q;
  volume_t                 notify_volume_q;

  // Count follows the command, saturating when the book is full
  always_comb begin
    count_nxt = count_q;
    case (i_cmd)
      CMD_CLEAR:  count_nxt = '0;
      CMD_ADD:    if (count_q != count_t'(ENTRIES_N)) count_nxt = count_q + 1'b1;
      CMD_DELETE: if (i_match_hit) count_nxt = count_q - 1'b1;
      default:    count_nxt = count_q;
    endcase
  end

  // Best entry is touched by the command
  assign notify_nxt = ((i_cmd == CMD_CLEAR) & vld_q[ENTRIES_N-1]) |
                      ((i_cmd == CMD_ADD) & i_insert_top) |
                      ((i_cmd == CMD_DELETE) & i_match_top) |
                      ((i_cmd == CMD_REPLACE) & i_match_top);

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      vld_q     <= '0;
      keys_q    <= '0;
      volumes_q <= '0;
      count_q   <= '0;
      notify_q  <= 1'b0;
    end else begin
      // Notify is a single-cycle pulse after exec
      notify_q <= i_exec & notify_nxt;
      if (i_exec) begin
        vld_q     <= i_vld_nxt;
        keys_q    <= i_keys_nxt;
        volumes_q <= i_volumes_nxt;
        count_q   <= count_nxt;
      end
    end
  end

  // Notify carries the best entry from before the command
  always_ff @(posedge i_clk) begin
    if (i_exec) begin
      notify_key_q    <= vld_q[ENTRIES_N-1] ? keys_q[ENTRIES_N-1] : '0;
      notify_volume_q <= vld_q[ENTRIES_N-1] ? volumes_q[ENTRIES_N-1] : '0;
    end
  end

  assign o_vld           = vld_q;
  assign o_keys          = keys_q;
  assign o_volumes       = volumes_q;
  assign o_count         = count_q;
  assign o_notify_vld    = notify_q;
  assign o_notify_key    = notify_key_q;
  assign o_notify_volume = notify_volume_q;
  // Invalid entries hold zero, so an empty book reads as zero
  assign o_best_key      = keys_q[ENTRIES_N-1];
  assign o_best_volume   = volumes_q[ENTRIES_N-1];

  // Valid entries packed from the top, no holes
  a_vld_contiguous: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    ((~vld_q) & ((~vld_q) + 1'b1)) == '0);

  // Count tracks the valid vector built in book_update
  a_count_matches: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    $countones(vld_q) == int'(count_q));

endmodule

// ==== hw/book_update.sv ====
// Book next-state update
module book_update import book_pkg::*; (
    input  cmd_t                     i_cmd
  , input  key_t                     i_key
  , input  volume_t                  i_volume
  , input  entry_mask_t              i_match_sel
  , input  logic                     i_match_hit
  , input  entry_mask_t              i_insert_sel
  , input  entry_mask_t              i_vld
  , input  key_t [ENTRIES_N-1:0]     i_keys
  , input  volume_t [ENTRIES_N-1:0]  i_volumes
  , output entry_mask_t              o_vld_nxt
  , output key_t [ENTRIES_N-1:0]     o_keys_nxt
  , output volume_t [ENTRIES_N-1:0]  o_volumes_nxt
);

  logic        op_clr;
  logic        op_add;
  logic        op_del;
  logic        op_rep;
  entry_mask_t ins_therm;
  entry_mask_t match_therm;
  entry_mask_t take_new;
  entry_mask_t take_above;
  entry_mask_t take_below;
  entry_mask_t take_volume;

  // Command decode, delete and replace only act on a hit
  assign op_clr = (i_cmd == CMD_CLEAR);
  assign op_add = (i_cmd == CMD_ADD);
  assign op_del = (i_cmd == CMD_DELETE) & i_match_hit;
  assign op_rep = (i_cmd == CMD_REPLACE) & i_match_hit;

  // Thermometers: the selected entry and every entry below it
  assign ins_therm   = (i_insert_sel != '0) ?
                       (i_insert_sel | (i_insert_sel - entry_mask_t'(1))) : '0;
  assign match_therm = (i_match_sel != '0) ?
                       (i_match_sel | (i_match_sel - entry_mask_t'(1))) : '0;

  // Add: new entry at the slot, lower entries shift down one place
  assign take_new    = op_add ? i_insert_sel : '0;
  assign take_above  = op_add ? (ins_therm & ~i_insert_sel) : '0;
  // Delete: matched entry and below pull up from the next lower entry
  assign take_below  = op_del ? match_therm : '0;
  // Replace: volume only
  assign take_volume = op_rep ? i_match_sel : '0;

  for (genvar i = 0; i < ENTRIES_N; i++) begin : g_entry
    logic    vld_above;
    key_t    key_above;
    volume_t volume_above;
    logic    vld_below;
    key_t    key_below;
    volume_t volume_below;
    logic    vld_n;
    key_t    key_n;
    volume_t volume_n;

    // Nothing sits above the best entry
    if (i == ENTRIES_N - 1) begin : g_top
      assign vld_above    = 1'b0;
      assign key_above    = '0;
      assign volume_above = '0;
    end else begin : g_not_top
      assign vld_above    = i_vld[i+1];
      assign key_above    = i_keys[i+1];
      assign volume_above = i_volumes[i+1];
    end

    // Bottom entry zero-fills on a delete
    if (i == 0) begin : g_bottom
      assign vld_below    = 1'b0;
      assign key_below    = '0;
      assign volume_below = '0;
    end else begin : g_not_bottom
      assign vld_below    = i_vld[i-1];
      assign key_below    = i_keys[i-1];
      assign volume_below = i_volumes[i-1];
    end

    always_comb begin
      vld_n    = i_vld[i];
      key_n    = i_keys[i];
      volume_n = i_volumes[i];
      if (op_clr) begin
        vld_n    = 1'b0;
        key_n    = '0;
        volume_n = '0;
      end else if (take_new[i]) begin
        vld_n    = 1'b1;
        key_n    = i_key;
        volume_n = i_volume;
      end else if (take_above[i]) begin
        vld_n    = vld_above;
        key_n    = key_above;
        volume_n = volume_above;
      end else if (take_below[i]) begin
        vld_n    = vld_below;
        key_n    = key_below;
        volume_n = volume_below;
      end else if (take_volume[i]) begin
        volume_n = i_volume;
      end
    end

    assign o_vld_nxt[i]     = vld_n;
    assign o_keys_nxt[i]    = key_n;
    assign o_volumes_nxt[i] = volume_n;
  end

endmodule

// ==== hw/book_match.sv ====
// Book key match and insertion point
module book_match import book_pkg::*; (
    input  key_t                  i_key
  , input  entry_mask_t           i_vld
  , input  key_t [ENTRIES_N-1:0]  i_keys
  , output entry_mask_t           o_match_sel
  , output logic                  o_match_hit
  , output entry_mask_t           o_insert_sel
);

  // Valid entries whose key is at least the command key
  entry_mask_t ge_mask;
  entry_mask_t match_sel;
  entry_mask_t insert_sel;

  for (genvar i = 0; i < ENTRIES_N; i++) begin : g_cmp
    // Exact key match, one-hot while keys stay unique
    assign match_sel[i] = i_vld[i] & (i_keys[i] == i_key);
    // Bid ordering: descending key from the top entry
    assign ge_mask[i]   = i_vld[i] & (i_keys[i] >= i_key);
  end

  // Leading-zero detect from the top of the ordering mask
  // Mask is a thermometer from the top, so the first zero sits just
  // below the last entry that outranks the new key
  always_comb begin
    logic seen_zero;
    seen_zero  = 1'b0;
    insert_sel = '0;
    for (int i = ENTRIES_N - 1; i >= 0; i--) begin
      insert_sel[i] = ~ge_mask[i] & ~seen_zero;
      seen_zero     = seen_zero | ~ge_mask[i];
    end
  end

  // All-ones mask leaves no slot: new key is below a full book

  assign o_match_sel  = match_sel;
  assign o_match_hit  = (match_sel != '0);
  assign o_insert_sel = insert_sel;

  // Keys in the book are unique, so at most one entry matches
  always_comb begin
    a_match_onehot: assert final ($onehot0(match_sel))
      else $error("book_match: multiple entries match key %h", i_key);
  end

endmodule

// ==== hw/book_cmd_port.sv ====
// Book command handshake port
module book_cmd_port import book_pkg::*; (
    input  logic        i_clk
  , input  logic        i_arst_n
  , input  logic        i_req
  , input  cmd_t        i_cmd
  , input  key_t        i_key
  , input  volume_t     i_volume
  , output logic        o_ack
  , output logic        o_exec
  , output cmd_t        o_cmd
  , output key_t        o_key
  , output volume_t     o_volume
);

  port_state_t state_q;
  port_state_t state_nxt;
  logic        ack_q;
  logic        capture;
  cmd_t        cmd_q;
  key_t        key_q;
  volume_t     volume_q;

  // New command only accepted from idle
  assign capture = (state_q == PORT_IDLE) & i_req;

  always_comb begin
    state_nxt = state_q;
    case (state_q)
      PORT_IDLE:     if (i_req) state_nxt = PORT_EXEC;
      // Book loads during this single cycle
      PORT_EXEC:     state_nxt = PORT_ACK;
      PORT_ACK:      state_nxt = PORT_WAIT_LOW;
      // Hold ack until requester lets go
      PORT_WAIT_LOW: if (!i_req) state_nxt = PORT_IDLE;
      default:       state_nxt = PORT_IDLE;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q <= PORT_IDLE;
      ack_q   <= 1'b0;
    end else begin
      state_q <= state_nxt;
      // Ack rises one cycle after the notify cycle
      if (state_q == PORT_ACK) begin
        ack_q <= 1'b1;
      end else if ((state_q == PORT_WAIT_LOW) && !i_req) begin
        ack_q <= 1'b0;
      end
    end
  end

  // Command payload, held stable while the book updates
  always_ff @(posedge i_clk) begin
    if (capture) begin
      cmd_q    <= i_cmd;
      key_q    <= i_key;
      volume_q <= i_volume;
    end
  end

  assign o_ack    = ack_q;
  assign o_exec   = (state_q == PORT_EXEC);
  assign o_cmd    = cmd_q;
  assign o_key    = key_q;
  assign o_volume = volume_q;

  // Exec never overlaps ack, and ack follows exec after two cycles
  a_exec_then_ack: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_exec |-> !o_ack ##2 o_ack);

endmodule

// ==== hw/book_pkg.sv ====
// Order book shared definitions
package book_pkg;

  // Number of price levels held on the bid side
  localparam int ENTRIES_N = 8;

  // Price key width
  localparam int KEY_BITS = 16;

  // Volume width
  localparam int VOLUME_BITS = 16;

  // Count must reach ENTRIES_N inclusive
  localparam int COUNT_BITS = $clog2(ENTRIES_N + 1);

  typedef logic [KEY_BITS-1:0]    key_t;
  typedef logic [VOLUME_BITS-1:0] volume_t;
  typedef logic [COUNT_BITS-1:0]  count_t;

  // One bit per entry, bit ENTRIES_N-1 is the best price
  typedef logic [ENTRIES_N-1:0]   entry_mask_t;

  // Book commands
  typedef enum logic [1:0] {
    CMD_CLEAR   = 2'd0,
    CMD_ADD     = 2'd1,
    CMD_DELETE  = 2'd2,
    CMD_REPLACE = 2'd3
  } cmd_t;

  // Command port handshake states
  typedef enum logic [1:0] {
    PORT_IDLE     = 2'd0,
    PORT_EXEC     = 2'd1,
    PORT_ACK      = 2'd2,
    PORT_WAIT_LOW = 2'd3
  } port_state_t;

endpackage
